/* Bender.yml */
package:
  name: taskwait

sources:
  - design/taskwait_pkg.sv
  - design/taskwait_msg_rx.sv
  - design/taskwait_table.sv
  - design/taskwait_engine.sv
  - design/taskwait_top.sv
  - target: simulation
    files:
      - verif/taskwait_checker.sv
      - verif/taskwait_monitor.sv
      - verif/taskwait_tb.sv

/* build.f */
design/taskwait_pkg.sv
design/taskwait_msg_rx.sv
design/taskwait_table.sv
design/taskwait_engine.sv
design/taskwait_top.sv
verif/taskwait_checker.sv
verif/taskwait_monitor.sv
verif/taskwait_tb.sv

/* design/taskwait_engine.sv */
// taskwait engine FSM that clears the table, searches it per message, updates counters, wakes waiters.
module taskwait_engine (
    input  logic                    clk,
    input  logic                    rstn,
    // request from receiver
    input  taskwait_pkg::tw_req_t   req,
    input  logic                    req_valid,
    output logic                    req_ready,
    // table port
    output logic                    mem_en,
    output logic                    mem_we,
    output taskwait_pkg::tw_idx_t   mem_addr,
    output taskwait_pkg::tw_entry_t mem_wdata,
    input  taskwait_pkg::tw_entry_t mem_rdata,
    // wakeup stream
    output logic                    wake_valid,
    output taskwait_pkg::acc_id_t   wake_dest,
    input  logic                    wake_ready,
    output logic                    overflow
);

    import taskwait_pkg::*;

    tw_state_t state;
    logic      clear_done;      // table sweep finished.
    tw_idx_t   idx;             // entry under visit.
    tw_idx_t   free_idx;        // first invalid entry seen.
    logic      free_found;
    tw_req_t   cur;             // request being processed.

    comp_t     base_cnt;        // counter before this message.
    acc_id_t   base_waiter;
    comp_t     new_cnt;
    acc_id_t   new_waiter;
    tw_entry_t upd_entry;

    logic      hit;
    logic      slot_free;
    logic      last_entry;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // search and update datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hit        = mem_rdata.valid && (mem_rdata.task_id == cur.task_id);
    assign slot_free  = !mem_rdata.valid;
    assign last_entry = (idx == tw_idx_t'(TW_ENTRIES - 1));

    always_comb begin
        if (cur.kind == TW_WAIT) begin
            new_cnt    = base_cnt - cur.components;   // wrapping subtract.
            new_waiter = cur.sender;
        end else begin
            new_cnt    = base_cnt + comp_t'(1);
            new_waiter = base_waiter;
        end
    end

    always_comb begin
        upd_entry.valid   = (new_cnt != '0);    // zero frees the entry.
        upd_entry.waiter  = new_waiter;
        upd_entry.counter = new_cnt;
        upd_entry.task_id = cur.task_id;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs decoded from state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_ready  = (state == IDLE) && clear_done;
    assign mem_en     = (state == CLEAR) || (state == READ) || (state == UPDATE);
    assign mem_we     = (state == CLEAR) || (state == UPDATE);
    assign mem_addr   = idx;
    assign mem_wdata  = (state == UPDATE) ? upd_entry : '0;    // clear writes invalid.
    assign wake_valid = (state == WAKE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            clear_done <= 1'b0;
            idx        <= '0;
            free_found <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;   // single-cycle strobe.
            case (state)
                IDLE: begin
                    if (!clear_done) begin
                        idx   <= '0;
                        state <= CLEAR;
                    end else if (req_valid) begin
                        idx        <= '0;
                        free_found <= 1'b0;
                        state      <= READ;
                    end
                end
                CLEAR: begin
                    idx <= idx + tw_idx_t'(1);  // wraps back to entry 0.
                    if (last_entry) begin
                        clear_done <= 1'b1;
                        state      <= IDLE;
                    end
                end
                READ: begin
                    state <= COMPARE;
                end
                COMPARE: begin
                    if (hit) begin
                        state <= UPDATE;        // idx already points at it.
                    end else if (last_entry) begin
                        if (free_found) begin
                            idx   <= free_idx;
                            state <= UPDATE;
                        end else if (slot_free) begin
                            state <= UPDATE;    // entry 15 is the only free one.
                        end else begin
                            overflow <= 1'b1;   // table full, message dropped.
                            state    <= IDLE;
                        end
                    end else begin
                        if (slot_free) begin
                            free_found <= 1'b1;
                        end
                        idx   <= idx + tw_idx_t'(1);
                        state <= READ;
                    end
                end
                UPDATE: begin
                    if (new_cnt == '0) begin
                        state <= WAKE;
                    end else begin
                        state <= IDLE;
                    end
                end
                WAKE: begin
                    if (wake_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur <= req;
        end
        if (state == COMPARE) begin
            if (slot_free && !free_found) begin
                free_idx <= idx;
            end
            if (hit) begin
                base_cnt    <= mem_rdata.counter;
                base_waiter <= mem_rdata.waiter;
            end else begin
                base_cnt    <= '0;          // new entry starts at zero.
                base_waiter <= cur.sender;
            end
        end
        if (state == UPDATE) begin
            wake_dest <= new_waiter;        // held through WAKE.
        end
    end

endmodule

/* design/taskwait_msg_rx.sv */
// taskwait message receiver, assembles header and task id beats into one held request.
module taskwait_msg_rx (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [63:0]           in_data,
    input  logic                  in_valid,
    input  taskwait_pkg::acc_id_t in_id,
    output logic                  in_ready,
    output taskwait_pkg::tw_req_t req,
    output logic                  req_valid,
    input  logic                  req_ready
);

    import taskwait_pkg::*;

    logic in_fire;          // beat accepted.
    logic req_fire;         // request taken by engine.
    logic tid_phase;        // next beat is the task id.
    logic req_valid_nxt;

    assign in_fire  = in_valid && in_ready;
    assign req_fire = req_valid && req_ready;

    // holding register occupancy for next cycle.
    always_comb begin
        req_valid_nxt = req_valid;
        if (req_fire) begin
            req_valid_nxt = 1'b0;
        end
        if (in_fire && tid_phase) begin
            req_valid_nxt = 1'b1;   // second beat completes the message.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tid_phase <= 1'b0;
            req_valid <= 1'b0;
            in_ready  <= 1'b0;
        end else begin
            req_valid <= req_valid_nxt;
            in_ready  <= !req_valid_nxt;    // open only while empty.
            if (in_fire) begin
                tid_phase <= !tid_phase;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (in_fire && !tid_phase) begin
            req.kind       <= tw_kind_t'(in_data[HDR_KIND_BIT]);
            req.components <= in_data[HDR_COMP_MSB:HDR_COMP_LSB];
            req.sender     <= in_id;    // sender comes with the header.
        end
        if (in_fire && tid_phase) begin
            req.task_id <= in_data;
        end
    end

endmodule

/* design/taskwait_pkg.sv */
// taskwait package with widths, header layout, request and entry types and engine states.
package taskwait_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and header layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ACC_BITS     = 4;    // accelerator number.
    localparam int TW_ENTRIES   = 16;   // taskwait table depth.
    localparam int TW_IDX_BITS  = 4;    // table index.

    localparam int HDR_COMP_LSB = 0;    // component count in header beat.
    localparam int HDR_COMP_MSB = 31;
    localparam int HDR_KIND_BIT = 32;   // 0 finish, 1 wait.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [ACC_BITS-1:0]    acc_id_t;
    typedef logic [63:0]            task_id_t;
    typedef logic [31:0]            comp_t;     // wraps on overflow.
    typedef logic [TW_IDX_BITS-1:0] tw_idx_t;

    typedef enum logic [0:0] {
        TW_FINISH = 1'b0,   // child finished, counter plus one.
        TW_WAIT   = 1'b1    // parent waits for components.
    } tw_kind_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // message and table entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one decoded two-beat message, 101 bits.
    typedef struct packed {
        tw_kind_t kind;
        comp_t    components;
        task_id_t task_id;
        acc_id_t  sender;
    } tw_req_t;

    // one taskwait table entry, 101 bits.
    typedef struct packed {
        logic     valid;
        acc_id_t  waiter;     // accelerator to wake.
        comp_t    counter;
        task_id_t task_id;
    } tw_entry_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        CLEAR,      // invalidate entries after reset.
        IDLE,       // wait for a request.
        READ,       // issue table read.
        COMPARE,    // check read entry.
        UPDATE,     // write entry back.
        WAKE        // present wakeup until taken.
    } tw_state_t;

endpackage

/* design/taskwait_table.sv */
// taskwait table, single-port synchronous RAM of entries with one-cycle read.
module taskwait_table (
    input  logic                    clk,
    input  logic                    mem_en,
    input  logic                    mem_we,
    input  taskwait_pkg::tw_idx_t   mem_addr,
    input  taskwait_pkg::tw_entry_t mem_wdata,
    output taskwait_pkg::tw_entry_t mem_rdata
);

    import taskwait_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    tw_entry_t mem [TW_ENTRIES];

    // write port.
    always_ff @(posedge clk) begin
        if (mem_en && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // registered read, output keeps its value while idle.
    always_ff @(posedge clk) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

/* design/taskwait_top.sv */
// taskwait manager top, joins the message receiver, engine and table to the streams.
module taskwait_top (
    input  logic                  clk,
    input  logic                  rstn,
    // message stream in
    input  logic [63:0]           in_data,
    input  logic                  in_valid,
    input  taskwait_pkg::acc_id_t in_id,
    output logic                  in_ready,
    // wakeup stream out
    output logic                  wake_valid,
    output taskwait_pkg::acc_id_t wake_dest,
    input  logic                  wake_ready,
    output logic                  overflow
);

    import taskwait_pkg::*;

    tw_req_t   req;
    logic      req_valid;
    logic      req_ready;

    logic      mem_en;
    logic      mem_we;
    tw_idx_t   mem_addr;
    tw_entry_t mem_wdata;
    tw_entry_t mem_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    taskwait_msg_rx u_msg_rx (
        .clk       (clk),
        .rstn      (rstn),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_id     (in_id),
        .in_ready  (in_ready),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready)
    );

    taskwait_engine u_engine (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .wake_valid (wake_valid),
        .wake_dest  (wake_dest),
        .wake_ready (wake_ready),
        .overflow   (overflow)
    );

    taskwait_table u_table (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

/* verif/taskwait_checker.sv */
// taskwait checker, concurrent assertions on the wakeup stream, reset values and overflow.
module taskwait_checker (
    input logic                  clk,
    input logic                  rstn,
    input logic                  in_ready,
    input logic                  wake_valid,
    input taskwait_pkg::acc_id_t wake_dest,
    input logic                  wake_ready,
    input logic                  overflow
);

    // stalled wakeup must hold.
    wake_stable: assert property (@(posedge clk) disable iff (!rstn)
        wake_valid && !wake_ready |=> wake_valid && $stable(wake_dest))
        else $error("wakeup changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        (!rstn ##1 !rstn) |-> !in_ready && !wake_valid)
        else $error("stream valid or ready high during reset");

    ovf_single: assert property (@(posedge clk) disable iff (!rstn)
        overflow |=> !overflow)
        else $error("overflow high two cycles in a row");

endmodule

/* verif/taskwait_monitor.sv */
// taskwait monitor that compares wakeups with the model queue and counts wakeups and overflows.
module taskwait_monitor (
    input logic                  clk,
    input logic                  rstn,
    input logic                  wake_valid,
    input taskwait_pkg::acc_id_t wake_dest,
    input logic                  wake_ready,
    input logic                  overflow
);

    import taskwait_pkg::*;

    acc_id_t exp_q [$];     // expected destinations in order.
    acc_id_t exp;
    int      err_cnt  = 0;
    int      wake_cnt = 0;
    int      ovf_cnt  = 0;

    task automatic push_expect(input acc_id_t dest);
        exp_q.push_back(dest);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wakeup and overflow checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (rstn) begin
            if (wake_valid && wake_ready) begin
                wake_cnt++;
                if (exp_q.size() == 0) begin
                    $display("unexpected wakeup to accelerator %0d at %0t", wake_dest, $time);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    if (exp != wake_dest) begin
                        $display("ERR %0t wake_dest expected %0d got %0d",
                                 $time, exp, wake_dest);
                        err_cnt++;
                    end
                end
            end
            if (overflow) begin
                ovf_cnt++;
            end
        end
    end

endmodule

/* verif/taskwait_tb.sv */
// taskwait testbench with clock, reset, LCG stimulus, back-pressure and a reference model.
module taskwait_tb;

    import taskwait_pkg::*;

    logic        clk;
    logic        rstn;
    logic [63:0] in_data;
    logic        in_valid;
    acc_id_t     in_id;
    logic        in_ready;
    logic        wake_valid;
    acc_id_t     wake_dest;
    logic        wake_ready;
    logic        overflow;

    logic [31:0] seed;
    logic [31:0] rdy_seed;      // separate stream for back-pressure.
    int          ready_mode;    // 0 ready, 1 random, 2 held low.
    int          tb_errs;
    int          pushes;
    int          tests;
    int          err_mark;
    int          push_mark;
    int          wake_mark;

    comp_t       m_cnt [task_id_t];     // model counters per task id.
    acc_id_t     m_wait [task_id_t];

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    taskwait_top dut (.*);

    taskwait_monitor mon (.*);

    bind taskwait_top taskwait_checker u_checker (.*);

    // wake_ready changes only on the falling edge.
    always @(negedge clk) begin
        rdy_seed = lcg_step(rdy_seed);
        case (ready_mode)
            0: wake_ready = 1'b1;
            1: wake_ready = (rdy_seed[29:28] != 2'b00);
            default: wake_ready = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_beat(input logic [63:0] data);
        int t;
        t        = 0;
        in_data  = data;
        in_valid = 1'b1;
        while (!in_ready && t < 1000) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low while a beat was waiting");
            tb_errs++;
        end
        @(posedge clk);     // beat transfers here.
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic apply_model(input tw_kind_t kind, input comp_t comp,
                               input task_id_t tid, input acc_id_t sender);
        comp_t   c;
        acc_id_t w;
        c = 0;
        w = sender;     // a new entry starts at zero.
        if (m_cnt.exists(tid)) begin
            c = m_cnt[tid];
            w = m_wait[tid];
        end
        if (kind == TW_WAIT) begin
            c = c - comp;
            w = sender;
        end else begin
            c = c + 1;
        end
        if (c == 0) begin
            m_cnt.delete(tid);
            m_wait.delete(tid);
            mon.push_expect(w);
            pushes++;
        end else begin
            m_cnt[tid]  = c;
            m_wait[tid] = w;
        end
    endtask

    task automatic send_msg(input tw_kind_t kind, input comp_t comp,
                            input task_id_t tid, input acc_id_t sender);
        in_id = sender;
        send_beat({31'b0, kind, comp});
        send_beat(tid);
        apply_model(kind, comp, tid, sender);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (!(mon.exp_q.size() == 0 && in_ready && dut.u_engine.req_ready
                 && !wake_valid) && t < 5000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 5000) begin
            $display("timeout: expected wakeups did not all arrive");
            tb_errs++;
        end
    endtask

    task automatic begin_test();
        err_mark  = tb_errs + mon.err_cnt;
        push_mark = pushes;
        wake_mark = mon.wake_cnt;
    endtask

    task automatic end_test(input string name);
        drain();
        if (mon.wake_cnt - wake_mark != pushes - push_mark) begin
            $display("%s saw %0d wakeups where %0d were expected", name,
                     mon.wake_cnt - wake_mark, pushes - push_mark);
            tb_errs++;
        end
        tests++;
        if (tb_errs + mon.err_cnt == err_mark) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail", name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        task_id_t keys [$];
        int       t;
        int       ovf_mark;
        rstn       = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        in_id      = '0;
        wake_ready = 1'b0;
        ready_mode = 0;
        tb_errs    = 0;
        pushes     = 0;
        tests      = 0;
        seed       = 32'h00273b7b;
        rdy_seed   = ~seed;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        begin_test();
        repeat (3) send_msg(TW_FINISH, 0, 64'h100, 4'd2);
        send_msg(TW_WAIT, 3, 64'h100, 4'd5);
        end_test("finish_before_wait");

        begin_test();
        send_msg(TW_WAIT, 3, 64'h200, 4'd7);
        repeat (3) begin
            drain();    // engine idle before each finish, wake only on the last.
            send_msg(TW_FINISH, 0, 64'h200, 4'd1);
        end
        end_test("wait_before_finish");

        begin_test();
        repeat (2) send_msg(TW_FINISH, 0, 64'h100, 4'd3);   // entry freed earlier.
        send_msg(TW_WAIT, 2, 64'h100, 4'd9);
        end_test("entry_reuse");

        begin_test();
        ready_mode = 2;
        send_msg(TW_WAIT, 0, 64'h300, 4'd4);
        send_msg(TW_WAIT, 0, 64'h301, 4'd6);
        t = 0;
        while (!(!in_ready && wake_valid) && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (t >= 200) begin
            $display("in_ready never dropped while a wakeup was stalled");
            tb_errs++;
        end
        ready_mode = 1;
        end_test("stalled_wakeup");

        begin_test();
        repeat (60) begin
            seed = lcg_step(seed);
            send_msg(tw_kind_t'(seed[16]), comp_t'(seed[19:18]),
                     64'hA000 + task_id_t'(seed[23:21]), acc_id_t'(seed[27:24]));
        end
        keys.delete();
        foreach (m_cnt[k]) keys.push_back(k);
        foreach (keys[i]) send_msg(TW_WAIT, m_cnt[keys[i]], keys[i], acc_id_t'(i));
        ready_mode = 0;
        end_test("random_interleave");

        begin_test();
        ovf_mark = mon.ovf_cnt;
        for (int i = 0; i < 17; i++) begin
            send_msg(TW_FINISH, 0, 64'h600 + task_id_t'(i), 4'd1);
        end
        t = 0;
        while (mon.ovf_cnt == ovf_mark && t < 500) begin
            @(negedge clk);
            t++;
        end
        drain();
        if (mon.ovf_cnt - ovf_mark != 1) begin
            $display("overflow strobed %0d times for a full table", mon.ovf_cnt - ovf_mark);
            tb_errs++;
        end
        end_test("table_overflow");

        $display("tests %0d, wakeups %0d, errors %0d", tests, mon.wake_cnt,
                 tb_errs + mon.err_cnt);
        if (tb_errs + mon.err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
